//--- design/fw_defines.svh
`ifndef FW_DEFINES_SVH
`define FW_DEFINES_SVH

// ====================
// Firmware table geometry
// ====================

// One table slot per 3-bit slot id.
`define FW_MAX_ROM 8

// Where downloaded images start in DDR3.
`define FW_BASE_ADDR 28'h500000

// Image header length in bytes.
`define FW_HEADER_BYTES 16

// Images are sized in 16 KiB blocks.
`define FW_BLOCK_SHIFT 14

// Host download index that carries firmware.
`define FW_INDEX 2

`endif

//--- design/fw_types_pkg.sv
`default_nettype none

package fw_types_pkg;

   // One table entry per loaded image.
   typedef struct packed {
      logic  [7:0] block_count;
      logic  [7:0] sram_block_count;
      logic [27:0] store_address;
   } fw_rom_t;

   // Slot identities.
   // Most slots carry generic images.
   typedef enum logic [2:0] {
      cart_gen_0,
      cart_fm_pac,
      cart_gm2,
      cart_gen_3,
      cart_gen_4,
      cart_gen_5,
      cart_gen_6,
      cart_gen_7
   } cart_type_e;

   // Battery SRAM blocks for a slot.
   function automatic logic [7:0] sram_blocks(cart_type_e slot);
      case (slot)
         cart_fm_pac: return 8'd2;
         cart_gm2:    return 8'd4;
         default:     return 8'd0;
      endcase
   endfunction

endpackage

`default_nettype wire

//--- design/fw_bus_pkg.sv
`default_nettype none

package fw_bus_pkg;

   // Byte read request towards the DDR3 controller.
   typedef struct packed {
      logic [27:0] addr;
      logic        rd;
      logic        request;
   } ddr_req_t;

   // Broadcast write to all slot stores.
   typedef struct packed {
      logic                  clear;
      logic                  we;
      logic            [2:0] id;
      fw_types_pkg::fw_rom_t rec;
   } slot_wr_t;

   typedef enum logic [1:0] {
      st_sleep,
      st_clean,
      st_parse,
      st_parse_block
   } parse_state_e;

endpackage

`default_nettype wire

//--- design/fw_header_parser.sv
`timescale 1ns/10ps
`include "fw_defines.svh"
`default_nettype none

module fw_header_parser (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 ioctl_download,
   input  wire logic          [15:0] ioctl_index,
   input  wire logic          [26:0] ioctl_addr,
   input  wire logic                 ddr3_ready,
   input  wire logic           [7:0] ddr3_dout,
   output fw_bus_pkg::ddr_req_t      ddr3,
   output fw_bus_pkg::slot_wr_t      slot_wr,
   input  wire logic                 update_ack,
   output logic                      update_request
);
   import fw_types_pkg::*;
   import fw_bus_pkg::*;

   parse_state_e state;
   logic         last_download;
   logic  [27:0] offset;
   logic   [3:0] head_addr;
   logic   [2:0] slot_id;
   logic         stored_any;
   logic         rd_q;
   logic  [27:0] rel_addr;
   logic         dl_end;
   logic         byte_valid;
   logic         past_end;
   logic         next_past_end;
   logic         magic_bad;
   logic         last_byte;
   logic         parse_done;

   // ====================
   // Address and status decode
   // ====================

   assign dl_end = last_download & ~ioctl_download
                 & (ioctl_index[5:0] == 6'(`FW_INDEX));

   // Offset of the current byte within the download.
   assign rel_addr      = offset + 28'(head_addr);
   assign past_end      = rel_addr > {1'b0, ioctl_addr};
   assign next_past_end = (rel_addr + 28'd1) > {1'b0, ioctl_addr};

   // A requested byte has arrived.
   assign byte_valid = (state == st_parse_block) & ddr3_ready & ~rd_q;
   assign last_byte  = head_addr == 4'd6;

   always_comb begin
      case (head_addr)
         4'd0:    magic_bad = ddr3_dout != "M";
         4'd1:    magic_bad = ddr3_dout != "S";
         4'd2:    magic_bad = ddr3_dout != "X";
         default: magic_bad = 1'b0;
      endcase
   end

   assign parse_done = ((state == st_parse) & past_end)
                     | (byte_valid & (magic_bad | (~last_byte & next_past_end)));

   assign ddr3 = '{addr:    `FW_BASE_ADDR + rel_addr,
                   rd:      rd_q,
                   request: state != st_sleep};

   // ====================
   // Table write
   // ====================

   always_comb begin
      slot_wr.clear                = state == st_clean;
      slot_wr.we                   = byte_valid & last_byte;
      slot_wr.id                   = slot_id;
      slot_wr.rec.block_count      = ddr3_dout;
      slot_wr.rec.sram_block_count = sram_blocks(cart_type_e'(slot_id));
      slot_wr.rec.store_address    = `FW_BASE_ADDR + offset + 28'(`FW_HEADER_BYTES);
   end

   // ====================
   // Header walk FSM
   // ====================

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state          <= st_sleep;
         last_download  <= 1'b0;
         offset         <= 28'd0;
         head_addr      <= 4'd0;
         slot_id        <= 3'd0;
         stored_any     <= 1'b0;
         rd_q           <= 1'b0;
         update_request <= 1'b0;
      end else begin
         last_download <= ioctl_download;
         rd_q          <= 1'b0;

         // Held until the consumer acknowledges.
         if (parse_done && stored_any)
            update_request <= 1'b1;
         else if (update_ack)
            update_request <= 1'b0;

         if (parse_done) begin
            state <= st_sleep;
         end else begin
            case (state)
               st_sleep: begin
                  if (dl_end) begin
                     offset     <= 28'd0;
                     head_addr  <= 4'd0;
                     stored_any <= 1'b0;
                     state      <= st_clean;
                  end
               end
               st_clean: begin
                  state <= st_parse;
               end
               st_parse: begin
                  if (ddr3_ready && !rd_q) begin
                     rd_q  <= 1'b1;
                     state <= st_parse_block;
                  end
               end
               st_parse_block: begin
                  if (byte_valid) begin
                     if (last_byte) begin
                        // Skip header and image body.
                        offset     <= offset + 28'(`FW_HEADER_BYTES)
                                    + (28'(ddr3_dout) << `FW_BLOCK_SHIFT);
                        head_addr  <= 4'd0;
                        stored_any <= 1'b1;
                        state      <= st_parse;
                     end else begin
                        if (head_addr == 4'd4)
                           slot_id <= ddr3_dout[2:0];
                        head_addr <= head_addr + 4'd1;
                        rd_q      <= 1'b1;
                     end
                  end
               end
               default: state <= st_sleep;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

//--- design/fw_slot_store.sv
`timescale 1ns/10ps
`default_nettype none

module fw_slot_store (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic           [2:0] slot_index,
   input  wire fw_bus_pkg::slot_wr_t slot_wr,
   output fw_types_pkg::fw_rom_t     rec
);

   logic hit;

   // Only the addressed slot takes the write.
   assign hit = slot_wr.we & (slot_wr.id == slot_index);

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rec <= '0;
      end else if (slot_wr.clear) begin
         rec <= '0;
      end else if (hit) begin
         rec <= slot_wr.rec;
      end
   end

endmodule

`default_nettype wire

//--- design/fw_slot_lookup.sv
`timescale 1ns/10ps
`include "fw_defines.svh"
`default_nettype none

module fw_slot_lookup (
   input  wire logic                  clk,
   input  wire logic                  rst_n,
   input  wire fw_types_pkg::fw_rom_t recs [`FW_MAX_ROM],
   input  wire logic            [2:0] query_id,
   output fw_types_pkg::fw_rom_t      query_rec
);

   // Registered read port with one cycle latency.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         query_rec <= '0;
      end else begin
         query_rec <= recs[query_id];
      end
   end

endmodule

`default_nettype wire

//--- design/fw_loader_top.sv
`timescale 1ns/10ps
`include "fw_defines.svh"
`default_nettype none

module fw_loader_top (
   input  wire logic                 clk,
   input  wire logic                 rst_n,
   input  wire logic                 ioctl_download,
   input  wire logic          [15:0] ioctl_index,
   input  wire logic          [26:0] ioctl_addr,
   input  wire logic                 ddr3_ready,
   input  wire logic           [7:0] ddr3_dout,
   output fw_bus_pkg::ddr_req_t      ddr3,
   input  wire logic                 update_ack,
   output logic                      update_request,
   input  wire logic           [2:0] query_id,
   output fw_types_pkg::fw_rom_t     query_rec
);
   import fw_types_pkg::*;
   import fw_bus_pkg::*;

   slot_wr_t slot_wr;
   fw_rom_t  recs [`FW_MAX_ROM];

   fw_header_parser u_fw_header_parser (
      .clk            (clk),
      .rst_n          (rst_n),
      .ioctl_download (ioctl_download),
      .ioctl_index    (ioctl_index),
      .ioctl_addr     (ioctl_addr),
      .ddr3_ready     (ddr3_ready),
      .ddr3_dout      (ddr3_dout),
      .ddr3           (ddr3),
      .slot_wr        (slot_wr),
      .update_ack     (update_ack),
      .update_request (update_request)
   );

   // ====================
   // Slot table
   // ====================

   for (genvar i = 0; i < `FW_MAX_ROM; i++) begin : g_slot
      fw_slot_store u_fw_slot_store (
         .clk        (clk),
         .rst_n      (rst_n),
         .slot_index (3'(i)),
         .slot_wr    (slot_wr),
         .rec        (recs[i])
      );
   end

   fw_slot_lookup u_fw_slot_lookup (
      .clk       (clk),
      .rst_n     (rst_n),
      .recs      (recs),
      .query_id  (query_id),
      .query_rec (query_rec)
   );

endmodule

`default_nettype wire

//--- tests/fw_loader_assert.sv
`timescale 1ns/10ps
`default_nettype none

module fw_loader_assert (
   input wire logic                 clk,
   input wire logic                 rst_n,
   input wire logic                 ddr3_ready,
   input wire fw_bus_pkg::ddr_req_t ddr3,
   input wire logic                 update_ack,
   input wire logic                 update_request
);

   int fail_count = 0;

   // Reads are one-cycle pulses.
   a_rd_pulse: assert property (@(posedge clk) disable iff (!rst_n)
      ddr3.rd |=> !ddr3.rd)
   else begin
      fail_count++;
      $error("rd stayed high for two cycles");
   end

   a_rd_ready: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(ddr3.rd) |-> $past(ddr3_ready))
   else begin
      fail_count++;
      $error("rd rose while the memory was not ready");
   end

   // Request is a level held until acknowledged.
   a_update_hold: assert property (@(posedge clk) disable iff (!rst_n)
      $fell(update_request) |-> $past(update_ack))
   else begin
      fail_count++;
      $error("update_request fell without update_ack");
   end

   a_reset_idle: assert property (@(posedge clk)
      $rose(rst_n) |-> !ddr3.request)
   else begin
      fail_count++;
      $error("request high right after reset release");
   end

endmodule

bind fw_loader_top fw_loader_assert u_fw_loader_assert (.*);

`default_nettype wire

//--- tests/tb_fw_loader.sv
`timescale 1ns/10ps
`include "fw_defines.svh"
`default_nettype none

module tb_fw_loader;
   import fw_types_pkg::*;
   import fw_bus_pkg::*;

   // Bytes of all downloads in the run with about 6 cycles per byte.
   localparam int image_bytes     = 49184 + 49184 + 16400;
   localparam int watchdog_cycles = image_bytes * 6 + 2000;

   logic        clk;
   logic        rst_n;
   logic        ioctl_download;
   logic [15:0] ioctl_index;
   logic [26:0] ioctl_addr;
   logic        ddr3_ready;
   logic  [7:0] ddr3_dout;
   ddr_req_t    ddr3;
   logic        update_ack;
   logic        update_request;
   logic  [2:0] query_id;
   fw_rom_t     query_rec;
   logic  [7:0] mem [0:65535];
   fw_rom_t     exp_tab [8];
   integer      seed;
   int          errors;
   int          tests_run;
   int          tests_failed;

   fw_loader_top u_fw_loader_top (.*);

   always #2 clk = ~clk;

   // ====================
   // DDR3 byte model
   // ====================

   initial begin
      logic [27:0] addr;
      int          wait_cycles;
      seed       = 32'hf4c008df;
      ddr3_ready = 1'b1;
      ddr3_dout  = 8'h00;
      forever begin
         @(posedge clk);
         #1;
         if (ddr3.rd) begin
            addr = ddr3.addr - `FW_BASE_ADDR;
            assert (addr[27:16] == 12'd0)
            else begin
               $display("read address %h is outside the download area", ddr3.addr);
               errors++;
            end
            ddr3_ready  = 1'b0;
            wait_cycles = 1 + int'({$random(seed)} % 4);
            repeat (wait_cycles) @(posedge clk);
            #1;
            ddr3_dout  = mem[addr[15:0]];
            ddr3_ready = 1'b1;
         end
      end
   end

   initial begin
      repeat (watchdog_cycles) @(posedge clk);
      $display("Timeout: parsing did not finish within %0d cycles.", watchdog_cycles);
      $display("SOME TESTS FAILED");
      $finish;
   end

   // ====================
   // Host and checks
   // ====================

   task automatic put_header(int offset, logic [2:0] slot, logic [7:0] blocks, bit good);
      for (int i = 0; i < `FW_HEADER_BYTES; i++)
         mem[16'(offset + i)] = 8'h00;
      mem[16'(offset)]     = good ? "M" : "B";
      mem[16'(offset + 1)] = "S";
      mem[16'(offset + 2)] = "X";
      mem[16'(offset + 4)] = {5'd0, slot};
      mem[16'(offset + 6)] = blocks;
   endtask

   // Header address, block count and slot give the expected record.
   function automatic fw_rom_t expect_rec(int slot, int blocks, int offset);
      fw_rom_t r;
      r.block_count      = 8'(blocks);
      r.sram_block_count = (slot == 1) ? 8'd2 : (slot == 2) ? 8'd4 : 8'd0;
      r.store_address    = `FW_BASE_ADDR + 28'(offset) + 28'd16;
      return r;
   endfunction

   task automatic download(logic [15:0] index, int last_offset);
      @(posedge clk);
      #1;
      ioctl_index    = index;
      ioctl_addr     = 27'(last_offset);
      ioctl_download = 1'b1;
      repeat (4) @(posedge clk);
      #1;
      ioctl_download = 1'b0;
   endtask

   task automatic check_val(string name, logic [43:0] exp, logic [43:0] act);
      assert (act === exp)
      else begin
         $display("mismatch %s: expected %h, actual %h", name, exp, act);
         errors++;
      end
   endtask

   // Request is due one cycle after the strobe falls.
   task automatic wait_parse(string name);
      @(posedge clk);
      #1;
      check_val({name, " request"}, 44'd1, 44'(ddr3.request));
      while (ddr3.request) begin
         @(posedge clk);
         #1;
      end
   endtask

   task automatic check_table(string name);
      for (int i = 0; i < `FW_MAX_ROM; i++) begin
         @(posedge clk);
         #1;
         query_id = 3'(i);
         @(posedge clk);
         #1;
         check_val($sformatf("%s slot %0d", name, i), exp_tab[i], query_rec);
      end
   endtask

   task automatic finish_test(string name, int mark);
      tests_run++;
      if (errors == mark) begin
         $display("test %s: ok", name);
      end else begin
         tests_failed++;
         $display("test %s: failed with %0d errors", name, errors - mark);
      end
   endtask

   initial begin
      int mark;
      clk            = 1'b0;
      rst_n          = 1'b0;
      ioctl_download = 1'b0;
      ioctl_index    = 16'd0;
      ioctl_addr     = 27'd0;
      update_ack     = 1'b0;
      query_id       = 3'd0;
      errors         = 0;
      tests_run      = 0;
      tests_failed   = 0;
      for (int i = 0; i < 65536; i++)
         mem[i] = 8'h00;
      exp_tab = '{default: '0};
      repeat (5) @(posedge clk);
      #1;
      rst_n = 1'b1;

      mark = errors;
      check_val("reset request", 44'd0, 44'(ddr3.request));
      check_val("reset update", 44'd0, 44'(update_request));
      check_table("reset");
      finish_test("reset", mark);

      mark = errors;
      put_header(0, 3'd1, 8'd1, 1'b1);
      download(16'd3, 16399);
      repeat (10) begin
         @(posedge clk);
         #1;
         check_val("index request", 44'd0, 44'(ddr3.request));
      end
      check_table("index");
      finish_test("index", mark);

      mark = errors;
      put_header(0, 3'd1, 8'd2, 1'b1);
      put_header(32784, 3'd5, 8'd1, 1'b1);
      download(16'(`FW_INDEX), 49183);
      wait_parse("two");
      exp_tab[1] = expect_rec(1, 2, 0);
      exp_tab[5] = expect_rec(5, 1, 32784);
      check_table("two");
      check_val("two update", 44'd1, 44'(update_request));
      finish_test("two", mark);

      mark = errors;
      put_header(0, 3'd2, 8'd3, 1'b1);
      put_header(49168, 3'd6, 8'd1, 1'b0);
      download(16'(`FW_INDEX), 49183);
      wait_parse("magic");
      exp_tab = '{default: '0};
      exp_tab[2] = expect_rec(2, 3, 0);
      check_table("magic");
      check_val("magic update", 44'd1, 44'(update_request));
      finish_test("magic", mark);

      mark = errors;
      put_header(0, 3'd1, 8'd1, 1'b1);
      put_header(16400, 3'd6, 8'd1, 1'b1);
      download(16'(`FW_INDEX), 16399);
      wait_parse("short");
      exp_tab = '{default: '0};
      exp_tab[1] = expect_rec(1, 1, 0);
      check_table("short");
      finish_test("short", mark);

      mark = errors;
      repeat (8) begin
         @(posedge clk);
         #1;
         check_val("ack hold", 44'd1, 44'(update_request));
      end
      update_ack = 1'b1;
      @(posedge clk);
      #1;
      update_ack = 1'b0;
      check_val("ack drop", 44'd0, 44'(update_request));
      finish_test("ack", mark);

      $display("%0d tests, %0d failed, %0d check errors, %0d assertion errors",
               tests_run, tests_failed, errors,
               u_fw_loader_top.u_fw_loader_assert.fail_count);
      if (errors == 0 && u_fw_loader_top.u_fw_loader_assert.fail_count == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
+incdir+design
design/fw_types_pkg.sv
design/fw_bus_pkg.sv
design/fw_header_parser.sv
design/fw_slot_store.sv
design/fw_slot_lookup.sv
design/fw_loader_top.sv
tests/fw_loader_assert.sv
tests/tb_fw_loader.sv

//--- Makefile
TOP := tb_fw_loader

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert --timescale 1ns/10ps -j 0 \
		--top-module $(TOP) -Mdir obj_dir -f list.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; \
		echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir
